//--- mipsCore.f
mipsIsaPkg.sv
mipsCtrlPkg.sv
mainControl.sv
pcUnit.sv
aluStage.sv
regFile.sv
mipsCore.sv
tbClockGen.sv
tbMipsCore.sv

//--- tbMipsCore.sv
// ================================================
// testbench for the single-cycle core
// memories answer through NBAs on the rising edge
// fetch and load data follow the model's next pc
// program must end in the self jump at haltIdx
// ================================================

`timescale 1ns/1ps

module tbMipsCore;

  localparam int progLen   = 26;
  localparam int haltIdx   = 23;
  localparam int timeoutNs = (progLen + 8) * 4 * 3;

  logic                                 clk;
  logic                                 rst;
  logic [mipsIsaPkg::dataWidth-1:0]     imemAddr;
  logic [mipsIsaPkg::dataWidth-1:0]     imemData;
  logic [mipsIsaPkg::dmemAddrWidth-1:0] dmemAddr;
  logic [mipsIsaPkg::dataWidth-1:0]     dmemWdata;
  logic [mipsIsaPkg::dataWidth-1:0]     dmemRdata;
  logic                                 dmemCen;
  logic                                 dmemWen;
  logic [mipsIsaPkg::dataWidth-1:0]     rfWriteData;

  // memories seen by the DUT
  logic [31:0] imem [0:31];
  logic [31:0] dmem [0:127];
  string       testName [0:31];

  // reference model state
  logic [31:0] refMem [0:127];
  logic [31:0] refRegs [0:31];
  logic [31:0] refPc;

  int   errors;
  int   checks;
  int   resetCycles;
  logic done;

  tbClockGen clockGen (.clk(clk), .rst(rst));

  mipsCore UUT (
    .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
    .dmemCen(dmemCen), .dmemWen(dmemWen), .rfWriteData(rfWriteData)
  );

  // ================================================
  // helpers
  // ================================================

  function automatic logic [31:0] nextRand(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input mipsIsaPkg::functT fn);
    return {mipsIsaPkg::opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(input mipsIsaPkg::opcodeT op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // index is the target word number
  function automatic logic [31:0] jType(input mipsIsaPkg::opcodeT op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  task automatic loadInstr(input int idx, input logic [31:0] word, input string name);
    imem[idx]     = word;
    testName[idx] = name;
  endtask

  task automatic checkValue(input string test, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("ERR %s %s expected %h actual %h", test, field, expected, actual);
    end
  endtask

  // ================================================
  // memory fill and program
  // ================================================

  initial begin
    logic [31:0] seed;
    seed = 32'he2de_2b1d;
    for (int i = 0; i < 128; i++) begin
      seed      = nextRand(seed);
      dmem[i]   = seed;
      refMem[i] = seed;
    end
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
      loadInstr(i, 32'd0, "nop");
    end
    loadInstr(1, iType(mipsIsaPkg::opLw, 0, 1, 16'd0), "lw random a");
    loadInstr(2, iType(mipsIsaPkg::opLw, 0, 2, 16'd4), "lw random b");
    loadInstr(3, iType(mipsIsaPkg::opLw, 0, 3, 16'd8), "lw random c");
    loadInstr(4, rType(1, 2, 4, mipsIsaPkg::fnAdd), "add");
    loadInstr(5, rType(1, 2, 5, mipsIsaPkg::fnSub), "sub");
    loadInstr(6, rType(1, 2, 6, mipsIsaPkg::fnAnd), "and");
    loadInstr(7, rType(1, 2, 7, mipsIsaPkg::fnOr), "or");
    loadInstr(8, rType(1, 2, 8, mipsIsaPkg::fnSlt), "slt");
    // r9 = -r3 makes one slt operand below negative
    loadInstr(9, rType(0, 3, 9, mipsIsaPkg::fnSub), "negate");
    loadInstr(10, rType(9, 3, 10, mipsIsaPkg::fnSlt), "slt negative rs");
    loadInstr(11, rType(3, 9, 11, mipsIsaPkg::fnSlt), "slt negative rt");
    loadInstr(12, iType(mipsIsaPkg::opSw, 0, 4, 16'd20), "sw");
    loadInstr(13, iType(mipsIsaPkg::opLw, 0, 12, 16'd20), "lw stored word");
    loadInstr(14, iType(mipsIsaPkg::opBeq, 1, 1, 16'd1), "beq taken");
    loadInstr(15, rType(1, 1, 13, mipsIsaPkg::fnAdd), "skipped add");
    loadInstr(16, iType(mipsIsaPkg::opBeq, 1, 2, 16'd1), "beq not taken");
    loadInstr(17, rType(1, 2, 0, mipsIsaPkg::fnAdd), "add to r0");
    loadInstr(18, rType(0, 3, 14, mipsIsaPkg::fnAdd), "add reads r0");
    loadInstr(19, jType(mipsIsaPkg::opJ, 26'd21), "j");
    loadInstr(20, rType(1, 1, 15, mipsIsaPkg::fnAdd), "skipped add");
    loadInstr(21, jType(mipsIsaPkg::opJal, 26'd24), "jal");
    loadInstr(22, rType(31, 0, 16, mipsIsaPkg::fnAdd), "link value");
    loadInstr(haltIdx, jType(mipsIsaPkg::opJ, 26'(haltIdx)), "halt");
    loadInstr(24, rType(1, 3, 17, mipsIsaPkg::fnAdd), "subroutine add");
    loadInstr(25, rType(31, 0, 0, mipsIsaPkg::fnJr), "jr");
    imemData    = '0;
    dmemRdata   = '0;
    refPc       = '0;
    errors      = 0;
    checks      = 0;
    resetCycles = 0;
    done        = 1'b0;
  end

  // ================================================
  // reference model, checks and memory ports
  // ================================================

  always @(posedge clk) begin : refStep
    logic [31:0] instr;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] sImm;
    logic [31:0] effAddr;
    logic [31:0] pcNext;
    logic [31:0] wrVal;
    logic [4:0]  wrReg;
    logic        wrEn;
    logic        isLoad;
    logic        isStore;
    string       test;
    if (!rst) begin
      // no check on the first edge since the pc clears there
      if (resetCycles > 0) begin
        checkValue("reset", "pc", 32'd0, imemAddr);
        checkValue("reset", "cen", 32'd1, dmemCen);
        checkValue("reset", "wen", 32'd1, dmemWen);
      end
      resetCycles++;
      imemData  <= '0;
      dmemRdata <= '0;
    end else if (!done) begin
      instr   = imem[refPc[6:2]];
      test    = testName[refPc[6:2]];
      opA     = refRegs[instr[25:21]];
      opB     = refRegs[instr[20:16]];
      sImm    = {{16{instr[15]}}, instr[15:0]};
      effAddr = opA + sImm;
      pcNext  = refPc + 32'd4;
      wrEn    = 1'b0;
      wrReg   = instr[15:11];
      wrVal   = '0;
      isLoad  = 1'b0;
      isStore = 1'b0;
      case (instr[31:26])
        mipsIsaPkg::opRtype: begin
          wrEn = 1'b1;
          case (instr[5:0])
            mipsIsaPkg::fnAdd: wrVal = opA + opB;
            mipsIsaPkg::fnSub: wrVal = opA - opB;
            mipsIsaPkg::fnAnd: wrVal = opA & opB;
            mipsIsaPkg::fnOr:  wrVal = opA | opB;
            mipsIsaPkg::fnSlt: wrVal = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
            mipsIsaPkg::fnJr: begin
              wrEn   = 1'b0;
              pcNext = opA;
            end
            default: wrEn = 1'b0;
          endcase
        end
        mipsIsaPkg::opLw: begin
          isLoad = 1'b1;
          wrEn   = 1'b1;
          wrReg  = instr[20:16];
          wrVal  = refMem[effAddr[8:2]];
        end
        mipsIsaPkg::opSw: isStore = 1'b1;
        // word offset relative to pc+4
        mipsIsaPkg::opBeq: begin
          if (opA == opB) begin
            pcNext = refPc + 32'd4 + {sImm[29:0], 2'b00};
          end
        end
        mipsIsaPkg::opJ: pcNext = {pcNext[31:28], instr[25:0], 2'b00};
        mipsIsaPkg::opJal: begin
          wrEn   = 1'b1;
          wrReg  = mipsIsaPkg::linkReg;
          wrVal  = refPc + 32'd4;
          pcNext = {pcNext[31:28], instr[25:0], 2'b00};
        end
        default: ;
      endcase

      checkValue(test, "pc", refPc, imemAddr);
      checkValue(test, "cen", !(isLoad || isStore), dmemCen);
      checkValue(test, "wen", !isStore, dmemWen);
      if (isLoad || isStore) begin
        checkValue(test, "dmem addr", effAddr[8:2], dmemAddr);
      end
      if (isStore) begin
        checkValue(test, "dmem wdata", opB, dmemWdata);
        refMem[effAddr[8:2]] = opB;
      end
      if (wrEn) begin
        checkValue(test, "write value", wrVal, rfWriteData);
      end
      if (wrEn && wrReg != 5'd0) begin
        refRegs[wrReg] = wrVal;
      end

      // data memory write from strobes sampled before the edge
      if (!dmemCen && !dmemWen) begin
        dmem[dmemAddr] = dmemWdata;
      end
      if (refPc == haltIdx * 4) begin
        done = 1'b1;
      end

      // next instruction and its load data for the coming cycle
      refPc     = pcNext;
      instr     = imem[refPc[6:2]];
      effAddr   = refRegs[instr[25:21]] + {{16{instr[15]}}, instr[15:0]};
      imemData  <= instr;
      dmemRdata <= dmem[effAddr[8:2]];
    end
  end

  // ================================================
  // end of run
  // ================================================

  initial begin : report
    wait (done === 1'b1);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeoutNs);
    $display("timeout, the program never reached its halt loop");
    $display("checks %0d errors %0d", checks, errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- tbClockGen.sv
// ================================================
// testbench clock and reset, 4 ns period
// rst low from time 0 for 8 rising edges
// ================================================

`timescale 1ns/1ps

module tbClockGen (
  output logic clk,
  output logic rst
);

  localparam int halfPeriodNs = 2;
  localparam int resetCycles  = 8;

  initial begin
    clk = 1'b0;
    forever #(halfPeriodNs) clk = ~clk;
  end

  // release on the last reset rising edge
  initial begin
    rst = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

//--- mipsCore.sv
// ================================================
// single-cycle MIPS core top level
// imemData and dmemRdata must be combinational
// data memory writes on clk when cen and wen low
// word accesses only, dmemAddr is a word index
// ================================================

`timescale 1ns/1ps

module mipsCore (
  input  logic                                 clk,
  input  logic                                 rst,
  output logic [mipsIsaPkg::dataWidth-1:0]     imemAddr,
  input  logic [mipsIsaPkg::dataWidth-1:0]     imemData,
  output logic [mipsIsaPkg::dmemAddrWidth-1:0] dmemAddr,
  output logic [mipsIsaPkg::dataWidth-1:0]     dmemWdata,
  input  logic [mipsIsaPkg::dataWidth-1:0]     dmemRdata,
  output logic                                 dmemCen,
  output logic                                 dmemWen,
  output logic [mipsIsaPkg::dataWidth-1:0]     rfWriteData
);

  // ================================================
  // instruction fields
  // ================================================

  mipsIsaPkg::opcodeT                  opcode;
  mipsIsaPkg::functT                   funct;
  logic [mipsIsaPkg::regAddrWidth-1:0] rsAddr;
  logic [mipsIsaPkg::regAddrWidth-1:0] rtAddr;
  logic [mipsIsaPkg::regAddrWidth-1:0] rdAddr;
  logic [15:0]                         imm;
  logic [25:0]                         jumpIndex;

  // decoder outputs
  mipsCtrlPkg::nextPcT nextPc;
  mipsCtrlPkg::aluOpT  aluOp;
  logic                useImm;
  logic                regWrite;
  mipsCtrlPkg::destT   destSel;
  mipsCtrlPkg::wbSelT  wbSel;
  logic                memRead;
  logic                memWrite;

  // datapath
  logic [mipsIsaPkg::dataWidth-1:0] aluResult;
  logic                             aluZero;
  logic [mipsIsaPkg::dataWidth-1:0] rsData;
  logic [mipsIsaPkg::dataWidth-1:0] rtData;
  logic [mipsIsaPkg::dataWidth-1:0] pcPlus4;

  assign opcode    = mipsIsaPkg::opcodeT'(imemData[31:26]);
  assign funct     = mipsIsaPkg::functT'(imemData[5:0]);
  assign rsAddr    = imemData[25:21];
  assign rtAddr    = imemData[20:16];
  assign rdAddr    = imemData[15:11];
  assign imm       = imemData[15:0];
  assign jumpIndex = imemData[25:0];

  // ================================================
  // data memory port
  // ================================================

  // byte address to word index, low two bits dropped
  assign dmemAddr  = aluResult[mipsIsaPkg::dmemAddrWidth+1:2];
  assign dmemWdata = rtData;
  // active-low strobes
  assign dmemCen   = ~(memRead | memWrite);
  assign dmemWen   = ~memWrite;

  mainControl uCtrl (
    .opcode(opcode), .funct(funct), .nextPc(nextPc), .aluOp(aluOp),
    .useImm(useImm), .regWrite(regWrite), .destSel(destSel),
    .wbSel(wbSel), .memRead(memRead), .memWrite(memWrite)
  );

  pcUnit uPc (
    .clk(clk), .rst(rst), .nextPc(nextPc), .aluZero(aluZero),
    .imm(imm), .jumpIndex(jumpIndex), .rsData(rsData),
    .pc(imemAddr), .pcPlus4(pcPlus4)
  );

  aluStage uAlu (
    .rsData(rsData), .rtData(rtData), .imm(imm), .useImm(useImm),
    .aluOp(aluOp), .aluResult(aluResult), .aluZero(aluZero)
  );

  // write-back value is brought out for observation
  regFile uRegs (
    .clk(clk), .rst(rst), .regWrite(regWrite),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .rdAddr(rdAddr),
    .destSel(destSel), .wbSel(wbSel), .aluResult(aluResult),
    .memData(dmemRdata), .pcPlus4(pcPlus4),
    .rsData(rsData), .rtData(rtData), .writeData(rfWriteData)
  );

endmodule

//--- regFile.sv
// ================================================
// 32 x 32 register file, two read ports
// register 0 has no storage and reads as zero
// writes on the rising edge, reads combinational
// ================================================

`timescale 1ns/1ps

module regFile (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                regWrite,
  input  logic [mipsIsaPkg::regAddrWidth-1:0] rsAddr,
  input  logic [mipsIsaPkg::regAddrWidth-1:0] rtAddr,
  input  logic [mipsIsaPkg::regAddrWidth-1:0] rdAddr,
  input  mipsCtrlPkg::destT                   destSel,
  input  mipsCtrlPkg::wbSelT                  wbSel,
  input  logic [mipsIsaPkg::dataWidth-1:0]    aluResult,
  input  logic [mipsIsaPkg::dataWidth-1:0]    memData,
  input  logic [mipsIsaPkg::dataWidth-1:0]    pcPlus4,
  output logic [mipsIsaPkg::dataWidth-1:0]    rsData,
  output logic [mipsIsaPkg::dataWidth-1:0]    rtData,
  output logic [mipsIsaPkg::dataWidth-1:0]    writeData
);

  // registers 1 to 31 only
  logic [mipsIsaPkg::dataWidth-1:0]    regs [1:31];
  logic [mipsIsaPkg::regAddrWidth-1:0] writeAddr;
  logic                                writeEn;

  // destination index
  always_comb begin
    case (destSel)
      mipsCtrlPkg::dstRt:   writeAddr = rtAddr;
      mipsCtrlPkg::dstRd:   writeAddr = rdAddr;
      mipsCtrlPkg::dstLink: writeAddr = mipsIsaPkg::linkReg;
      default:              writeAddr = '0;
    endcase
  end

  // write-back value, also visible outside the core
  always_comb begin
    case (wbSel)
      mipsCtrlPkg::wbAlu:  writeData = aluResult;
      mipsCtrlPkg::wbMem:  writeData = memData;
      mipsCtrlPkg::wbLink: writeData = pcPlus4;
      default:             writeData = aluResult;
    endcase
  end

  // writes to $0 are dropped here
  assign writeEn = regWrite && (writeAddr != '0);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeAddr] <= writeData;
    end
  end

  // read ports, no write-through bypass needed in a single cycle core
  assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

//--- aluStage.sv
// ================================================
// ALU with second operand select
// immediate is always sign extended
// slt compares as signed, zero flag for sub only
// ================================================

`timescale 1ns/1ps

module aluStage (
  input  logic [mipsIsaPkg::dataWidth-1:0] rsData,
  input  logic [mipsIsaPkg::dataWidth-1:0] rtData,
  input  logic [15:0]                      imm,
  input  logic                             useImm,
  input  mipsCtrlPkg::aluOpT               aluOp,
  output logic [mipsIsaPkg::dataWidth-1:0] aluResult,
  output logic                             aluZero
);

  logic [mipsIsaPkg::dataWidth-1:0] immExt;
  logic [mipsIsaPkg::dataWidth-1:0] operandB;
  logic                             lessThan;

  // operand b, rt or the offset for lw and sw
  assign immExt   = {{16{imm[15]}}, imm};
  assign operandB = useImm ? immExt : rtData;

  // signed compare for slt
  assign lessThan = $signed(rsData) < $signed(operandB);

  always_comb begin
    case (aluOp)
      mipsCtrlPkg::aluAdd: aluResult = rsData + operandB;
      mipsCtrlPkg::aluSub: aluResult = rsData - operandB;
      mipsCtrlPkg::aluAnd: aluResult = rsData & operandB;
      mipsCtrlPkg::aluOr:  aluResult = rsData | operandB;
      mipsCtrlPkg::aluSlt: begin
        aluResult = {{(mipsIsaPkg::dataWidth-1){1'b0}}, lessThan};
      end
      // aluNone and anything else
      default:             aluResult = '0;
    endcase
  end

  // equality test for beq
  // qualified with sub so other ops never raise it
  assign aluZero = (aluOp == mipsCtrlPkg::aluSub) && (aluResult == '0);

endmodule

//--- pcUnit.sv
// ================================================
// program counter and next address selection
// branch taken only when aluZero is set
// jump keeps the upper four bits of pc+4
// ================================================

`timescale 1ns/1ps

module pcUnit (
  input  logic                               clk,
  input  logic                               rst,
  input  mipsCtrlPkg::nextPcT                nextPc,
  input  logic                               aluZero,
  input  logic [15:0]                        imm,
  input  logic [25:0]                        jumpIndex,
  input  logic [mipsIsaPkg::dataWidth-1:0]   rsData,
  output logic [mipsIsaPkg::dataWidth-1:0]   pc,
  output logic [mipsIsaPkg::dataWidth-1:0]   pcPlus4
);

  logic [mipsIsaPkg::dataWidth-1:0] branchOffset;
  logic [mipsIsaPkg::dataWidth-1:0] branchTarget;
  logic [mipsIsaPkg::dataWidth-1:0] jumpTarget;
  logic [mipsIsaPkg::dataWidth-1:0] pcNext;

  // sequential address
  assign pcPlus4 = pc + 32'd4;

  // word offset, sign extended and scaled to bytes
  assign branchOffset = {{14{imm[15]}}, imm, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;

  // pseudo-direct jump within the current 256 MB region
  assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

  // ================================================
  // next pc mux
  // ================================================

  always_comb begin
    case (nextPc)
      mipsCtrlPkg::pcSeq:    pcNext = pcPlus4;
      // not-taken branch falls through
      mipsCtrlPkg::pcBranch: pcNext = aluZero ? branchTarget : pcPlus4;
      mipsCtrlPkg::pcJump:   pcNext = jumpTarget;
      mipsCtrlPkg::pcReg:    pcNext = rsData;
      default:               pcNext = pcPlus4;
    endcase
  end

  // one instruction per clock
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

//--- mainControl.sv
// ================================================
// main decoder, purely combinational
// unknown opcodes and functs decode to no writes
// all-zero instruction leaves memory idle
// ================================================

`timescale 1ns/1ps

module mainControl (
  input  mipsIsaPkg::opcodeT  opcode,
  input  mipsIsaPkg::functT   funct,
  output mipsCtrlPkg::nextPcT nextPc,
  output mipsCtrlPkg::aluOpT  aluOp,
  output logic                useImm,
  output logic                regWrite,
  output mipsCtrlPkg::destT   destSel,
  output mipsCtrlPkg::wbSelT  wbSel,
  output logic                memRead,
  output logic                memWrite
);

  always_comb begin
    // idle defaults, equal to a nop
    nextPc   = mipsCtrlPkg::pcSeq;
    aluOp    = mipsCtrlPkg::aluNone;
    useImm   = 1'b0;
    regWrite = 1'b0;
    destSel  = mipsCtrlPkg::dstRt;
    wbSel    = mipsCtrlPkg::wbAlu;
    memRead  = 1'b0;
    memWrite = 1'b0;

    case (opcode)
      mipsIsaPkg::opRtype: begin
        // register ops write rd
        destSel = mipsCtrlPkg::dstRd;
        case (funct)
          mipsIsaPkg::fnAdd: begin
            aluOp    = mipsCtrlPkg::aluAdd;
            regWrite = 1'b1;
          end
          mipsIsaPkg::fnSub: begin
            aluOp    = mipsCtrlPkg::aluSub;
            regWrite = 1'b1;
          end
          mipsIsaPkg::fnAnd: begin
            aluOp    = mipsCtrlPkg::aluAnd;
            regWrite = 1'b1;
          end
          mipsIsaPkg::fnOr: begin
            aluOp    = mipsCtrlPkg::aluOr;
            regWrite = 1'b1;
          end
          mipsIsaPkg::fnSlt: begin
            aluOp    = mipsCtrlPkg::aluSlt;
            regWrite = 1'b1;
          end
          // jump through rs, nothing written back
          mipsIsaPkg::fnJr: nextPc = mipsCtrlPkg::pcReg;
          default: ;
        endcase
      end
      mipsIsaPkg::opJ: nextPc = mipsCtrlPkg::pcJump;
      mipsIsaPkg::opJal: begin
        // return address pc+4 into r31
        nextPc   = mipsCtrlPkg::pcJump;
        regWrite = 1'b1;
        destSel  = mipsCtrlPkg::dstLink;
        wbSel    = mipsCtrlPkg::wbLink;
      end
      mipsIsaPkg::opBeq: begin
        // rs - rt sets the zero flag, pcUnit decides
        aluOp  = mipsCtrlPkg::aluSub;
        nextPc = mipsCtrlPkg::pcBranch;
      end
      mipsIsaPkg::opLw: begin
        aluOp    = mipsCtrlPkg::aluAdd;
        useImm   = 1'b1;
        regWrite = 1'b1;
        wbSel    = mipsCtrlPkg::wbMem;
        memRead  = 1'b1;
      end
      mipsIsaPkg::opSw: begin
        aluOp    = mipsCtrlPkg::aluAdd;
        useImm   = 1'b1;
        memWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- mipsCtrlPkg.sv
// ================================================
// control encodings between decoder and datapath
// internal to the core, not part of the ISA
// ================================================

package mipsCtrlPkg;

  // ALU operation, aluNone forces a zero result
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOpT;

  // next pc source
  // pcBranch is only taken when the ALU zero flag is set
  typedef enum logic [1:0] {
    pcSeq,
    pcBranch,
    pcJump,
    pcReg
  } nextPcT;

  // register file destination index
  typedef enum logic [1:0] {
    dstRt,
    dstRd,
    dstLink
  } destT;

  // register file write-back source
  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbLink
  } wbSelT;

endpackage

//--- mipsIsaPkg.sv
// ================================================
// MIPS instruction set widths and encodings
// only the subset the core executes is encoded
// data memory is word addressed, 128 words deep
// ================================================

package mipsIsaPkg;

  // ================================================
  // widths
  // ================================================

  // machine word and register index
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;

  // word address into data memory, byte address bits 8..2
  localparam int dmemAddrWidth = 7;

  // jal return address register
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // ================================================
  // encodings
  // ================================================

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    opRtype = 6'd0,
    opJ     = 6'd2,
    opJal   = 6'd3,
    opBeq   = 6'd4,
    opLw    = 6'd35,
    opSw    = 6'd43
  } opcodeT;

  // R-type function field, instr[5:0]
  typedef enum logic [5:0] {
    fnJr  = 6'd8,
    fnAdd = 6'd32,
    fnSub = 6'd34,
    fnAnd = 6'd36,
    fnOr  = 6'd37,
    fnSlt = 6'd42
  } functT;

endpackage
